// File: hw/hood_pkg.sv
`default_nettype none

package hood_pkg;

    ////////////////////////////////////////
    // timing and defaults
    ////////////////////////////////////////

    // short second for simulation, board build uses the real clock rate
    localparam int TICKS_PER_SEC       = 1000;
    localparam int HURRICANE_SECS      = 60;   // one-shot boost length
    localparam int REMINDER_DEFAULT_HR = 10;

    localparam logic [3:0] BCD_SEPARATOR = 4'hf;  // blank nibble between digit pairs

    ////////////////////////////////////////
    // operating modes
    ////////////////////////////////////////

    typedef logic [2:0] mode_t;

    localparam mode_t MODE_STANDBY       = 3'd0;
    localparam mode_t MODE_GEAR1         = 3'd1;
    localparam mode_t MODE_GEAR2         = 3'd2;
    localparam mode_t MODE_HURRICANE     = 3'd3;  // gear 3
    localparam mode_t MODE_SHOW_REMINDER = 3'd5;

    // time fields
    typedef logic [5:0] sec_t;  // 0..59
    typedef logic [5:0] min_t;  // 0..59
    typedef logic [4:0] hr_t;   // 0..23

    typedef enum logic [1:0] {
        FIELD_SEC,
        FIELD_MIN,
        FIELD_HR
    } field_t;

    // hh F mm F ss, top nibble first
    typedef logic [31:0] bcd_time_t;

endpackage

`default_nettype wire

// File: hw/second_tick.sv
`timescale 1ns/1ps
`default_nettype none

module second_tick
    import hood_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire mode_t mode,
    input  wire        hand_clean,
    output logic       tick
);

    localparam int CNT_W = $clog2(TICKS_PER_SEC);

    logic [CNT_W-1:0] cnt;
    logic             fan_run;

    // fan turns in gears 1 to 3 only
    assign fan_run = (mode == MODE_GEAR1) || (mode == MODE_GEAR2) ||
                     (mode == MODE_HURRICANE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (!fan_run || hand_clean) begin
            cnt  <= '0;   // partial second is dropped
            tick <= 1'b0;
        end else if (cnt == CNT_W'(TICKS_PER_SEC - 1)) begin
            cnt  <= '0;
            tick <= 1'b1; // lands TICKS_PER_SEC cycles after fan start
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/runtime_counter.sv
`timescale 1ns/1ps
`default_nettype none

module runtime_counter
    import hood_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   tick,
    input  wire   hand_clean,
    output hr_t   run_hr,
    output min_t  run_min,
    output sec_t  run_sec
);

    logic sec_wrap;
    logic min_wrap;

    assign sec_wrap = (run_sec == 6'd59);
    assign min_wrap = (run_min == 6'd59);

    ////////////////////////////////////////
    // cascaded hh:mm:ss counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            run_hr  <= '0;
            run_min <= '0;
            run_sec <= '0;
        end else if (hand_clean) begin
            // filter cleaned, start over
            run_hr  <= '0;
            run_min <= '0;
            run_sec <= '0;
        end else if (tick) begin
            if (sec_wrap) begin
                run_sec <= '0;
                if (min_wrap) begin
                    run_min <= '0;
                    run_hr  <= (run_hr == 5'd23) ? 5'd0 : run_hr + 5'd1;  // day wrap
                end else begin
                    run_min <= run_min + 6'd1;
                end
            end else begin
                run_sec <= run_sec + 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/hurricane_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hurricane_ctrl
    import hood_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire mode_t mode,
    input  wire        machine_state,
    input  wire        menu_btn,
    input  wire        tick,
    output min_t       cd_min,
    output sec_t       cd_sec,
    output logic       hurricane_enabled,
    output logic       return_state,
    output logic       hurricane_done
);

    typedef enum logic [1:0] {
        ARMED,
        RUNNING,
        SPENT
    } state_t;

    localparam min_t LOAD_MIN = min_t'(HURRICANE_SECS / 60);
    localparam sec_t LOAD_SEC = sec_t'(HURRICANE_SECS % 60);

    state_t state;
    logic   ms_prev;
    logic   power_on;
    logic   cd_zero;

    assign power_on = machine_state & ~ms_prev;  // rising edge of power
    assign cd_zero  = (cd_min == '0) && (cd_sec == '0);

    // boost is available until it has been used once
    assign hurricane_enabled = (state != SPENT);

    ////////////////////////////////////////
    // boost FSM and countdown
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= ARMED;
            ms_prev        <= 1'b0;
            cd_min         <= LOAD_MIN;
            cd_sec         <= LOAD_SEC;
            return_state   <= 1'b0;
            hurricane_done <= 1'b0;
        end else begin
            ms_prev        <= machine_state;
            hurricane_done <= 1'b0;
            if (power_on) begin
                state  <= ARMED;   // re-arm on every power on
                cd_min <= LOAD_MIN;
                cd_sec <= LOAD_SEC;
            end else begin
                case (state)
                    ARMED: begin
                        if (mode == MODE_HURRICANE) state <= RUNNING;
                    end
                    RUNNING: begin
                        if (menu_btn) begin
                            state          <= SPENT;
                            return_state   <= 1'b0;  // back to standby
                            hurricane_done <= 1'b1;
                        end else if (tick) begin
                            if (cd_zero) begin
                                state          <= SPENT;
                                return_state   <= 1'b1;  // drop to gear 2
                                hurricane_done <= 1'b1;
                            end else if (cd_sec == '0) begin
                                cd_min <= cd_min - 6'd1;
                                cd_sec <= 6'd59;
                            end else begin
                                cd_sec <= cd_sec - 6'd1;
                            end
                        end
                    end
                    default: ; // SPENT holds until power cycles
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/reminder_setting.sv
`timescale 1ns/1ps
`default_nettype none

module reminder_setting
    import hood_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       machine_state,
    input  wire       btn_up,
    input  wire       btn_left,
    input  wire       btn_right,
    input  wire       btn_down,
    input  wire hr_t  run_hr,
    input  wire min_t run_min,
    input  wire sec_t run_sec,
    output hr_t       rem_hr,
    output min_t      rem_min,
    output sec_t      rem_sec,
    output logic      need_clean
);

    logic        adjust;   // edit mode
    field_t      field;
    logic [16:0] run_total;
    logic [16:0] rem_total;

    // one step up or down, wrapping inside 0..top
    function automatic logic [5:0] wrap_step(input logic [5:0] v, input logic [5:0] top,
                                             input logic inc);
        if (inc) begin
            return (v >= top) ? 6'd0 : v + 6'd1;
        end
        return (v == 6'd0) ? top : v - 6'd1;
    endfunction

    function automatic logic [16:0] to_secs(input hr_t h, input min_t m, input sec_t s);
        return 17'(h) * 17'd3600 + 17'(m) * 17'd60 + 17'(s);
    endfunction

    ////////////////////////////////////////
    // threshold editing
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            adjust  <= 1'b0;
            field   <= FIELD_SEC;
            rem_hr  <= hr_t'(REMINDER_DEFAULT_HR);
            rem_min <= '0;
            rem_sec <= '0;
        end else begin
            if (btn_down && machine_state) adjust <= ~adjust;

            if (adjust) begin
                if (btn_up) begin
                    case (field)
                        FIELD_SEC: field <= FIELD_MIN;
                        FIELD_MIN: field <= FIELD_HR;
                        default:   field <= FIELD_SEC;
                    endcase
                end
                // right adds, left subtracts
                if (btn_right || btn_left) begin
                    case (field)
                        FIELD_SEC: rem_sec <= wrap_step(rem_sec, 6'd59, btn_right);
                        FIELD_MIN: rem_min <= wrap_step(rem_min, 6'd59, btn_right);
                        default:   rem_hr  <= hr_t'(wrap_step({1'b0, rem_hr}, 6'd23, btn_right));
                    endcase
                end
            end
        end
    end

    // compare in whole seconds
    assign run_total = to_secs(run_hr, run_min, run_sec);
    assign rem_total = to_secs(rem_hr, rem_min, rem_sec);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            need_clean <= 1'b0;
        end else begin
            need_clean <= machine_state && (run_total >= rem_total);  // only while on
        end
    end

endmodule

`default_nettype wire

// File: hw/display_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module display_formatter
    import hood_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire mode_t mode,
    input  wire hr_t   run_hr,
    input  wire min_t  run_min,
    input  wire sec_t  run_sec,
    input  wire min_t  cd_min,
    input  wire sec_t  cd_sec,
    input  wire hr_t   rem_hr,
    input  wire min_t  rem_min,
    input  wire sec_t  rem_sec,
    output bcd_time_t  display_data
);

    typedef enum logic [1:0] {
        SRC_RUN,
        SRC_CD,
        SRC_REM
    } src_t;

    src_t sel;
    src_t sel_nxt;
    hr_t  show_hr;
    min_t show_min;
    sec_t show_sec;

    // tens and units digit of a 0..59 value
    function automatic logic [7:0] to_bcd(input logic [5:0] v);
        return {4'(v / 6'd10), 4'(v % 6'd10)};
    endfunction

    // sticky source, unlisted modes keep the last one
    always_comb begin
        case (mode)
            MODE_GEAR1, MODE_GEAR2: sel_nxt = SRC_RUN;
            MODE_HURRICANE:         sel_nxt = SRC_CD;
            MODE_SHOW_REMINDER:     sel_nxt = SRC_REM;
            default:                sel_nxt = sel;
        endcase
    end

    always_comb begin
        case (sel_nxt)
            SRC_CD: begin
                show_hr  = '0;    // countdown has no hours
                show_min = cd_min;
                show_sec = cd_sec;
            end
            SRC_REM: begin
                show_hr  = rem_hr;
                show_min = rem_min;
                show_sec = rem_sec;
            end
            default: begin
                show_hr  = run_hr;
                show_min = run_min;
                show_sec = run_sec;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel          <= SRC_RUN;
            display_data <= {8'h00, BCD_SEPARATOR, 8'h00, BCD_SEPARATOR, 8'h00};
        end else begin
            sel          <= sel_nxt;
            display_data <= {to_bcd({1'b0, show_hr}), BCD_SEPARATOR,
                             to_bcd(show_min), BCD_SEPARATOR,
                             to_bcd(show_sec)};
        end
    end

endmodule

`default_nettype wire

// File: hw/hood_timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module hood_timer_top
    import hood_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire mode_t mode,
    input  wire        machine_state,
    input  wire        hand_clean,
    input  wire        menu_btn,
    input  wire        btn_up,
    input  wire        btn_left,
    input  wire        btn_right,
    input  wire        btn_down,
    output bcd_time_t  display_data,
    output logic       return_state,
    output logic       hurricane_enabled,
    output logic       hurricane_done,
    output logic       need_clean
);

    logic tick;   // one second of fan run
    hr_t  run_hr;
    min_t run_min;
    sec_t run_sec;
    min_t cd_min;
    sec_t cd_sec;
    hr_t  rem_hr;
    min_t rem_min;
    sec_t rem_sec;

    second_tick u_second_tick (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .hand_clean (hand_clean),
        .tick       (tick)
    );

    runtime_counter u_runtime_counter (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .hand_clean (hand_clean),
        .run_hr     (run_hr),
        .run_min    (run_min),
        .run_sec    (run_sec)
    );

    hurricane_ctrl u_hurricane_ctrl (
        .clk               (clk),
        .rst               (rst),
        .mode              (mode),
        .machine_state     (machine_state),
        .menu_btn          (menu_btn),
        .tick              (tick),
        .cd_min            (cd_min),
        .cd_sec            (cd_sec),
        .hurricane_enabled (hurricane_enabled),
        .return_state      (return_state),
        .hurricane_done    (hurricane_done)
    );

    reminder_setting u_reminder_setting (
        .clk           (clk),
        .rst           (rst),
        .machine_state (machine_state),
        .btn_up        (btn_up),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .btn_down      (btn_down),
        .run_hr        (run_hr),
        .run_min       (run_min),
        .run_sec       (run_sec),
        .rem_hr        (rem_hr),
        .rem_min       (rem_min),
        .rem_sec       (rem_sec),
        .need_clean    (need_clean)
    );

    display_formatter u_display_formatter (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .run_hr       (run_hr),
        .run_min      (run_min),
        .run_sec      (run_sec),
        .cd_min       (cd_min),
        .cd_sec       (cd_sec),
        .rem_hr       (rem_hr),
        .rem_min      (rem_min),
        .rem_sec      (rem_sec),
        .display_data (display_data)
    );

endmodule

`default_nettype wire

// File: sim/hood_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module hood_asserts
    import hood_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire            machine_state,
    input wire            need_clean,
    input wire            hurricane_done,
    input wire bcd_time_t display_data
);

    int fails = 0;  // read by the testbench at the end

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst)
        hurricane_done |=> !hurricane_done)
        else begin
            fails++;
            $error("hurricane_done held longer than one cycle");
        end

    // flag is registered, so it lags power by one cycle
    clean_needs_power: assert property (@(posedge clk) disable iff (!rst)
        need_clean |-> $past(machine_state))
        else begin
            fails++;
            $error("need_clean high without machine_state");
        end

    separators: assert property (@(posedge clk) disable iff (!rst)
        display_data[23:20] == BCD_SEPARATOR && display_data[11:8] == BCD_SEPARATOR)
        else begin
            fails++;
            $error("display separator nibble is not 15");
        end

endmodule

bind hood_timer_top hood_asserts u_asserts (
    .clk            (clk),
    .rst            (rst),
    .machine_state  (machine_state),
    .need_clean     (need_clean),
    .hurricane_done (hurricane_done),
    .display_data   (display_data)
);

`default_nettype wire

// File: sim/hood_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hood_checker
    import hood_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire mode_t     mode,
    input wire            machine_state,
    input wire            hand_clean,
    input wire            menu_btn,
    input wire            btn_up,
    input wire            btn_left,
    input wire            btn_right,
    input wire            btn_down,
    input wire bcd_time_t display_data,
    input wire            return_state,
    input wire            hurricane_enabled,
    input wire            hurricane_done,
    input wire            need_clean
);

    localparam int ST_ARMED   = 0;
    localparam int ST_RUNNING = 1;
    localparam int ST_SPENT   = 2;

    int        mismatch_cnt = 0;
    int        m_fan_cycles;     // fan-run cycles since the last tick
    bit        m_tick;
    int        m_run;            // runtime in seconds
    int        m_cd;             // countdown in seconds
    int        m_state;
    bit        m_ms_prev;
    bit        m_ret;
    bit        m_done;
    bit        m_adjust;
    field_t    m_field;
    int        m_rem_h;
    int        m_rem_m;
    int        m_rem_s;
    int        m_sel;            // 0 runtime, 1 countdown, 2 threshold
    bit        m_need;
    bcd_time_t m_display;
    bit        fan;

    // expected display word for a time given as h, m, s
    function automatic bcd_time_t expected_word(input int h, input int m, input int s);
        return {4'(h / 10), 4'(h % 10), 4'hf, 4'(m / 10), 4'(m % 10), 4'hf,
                4'(s / 10), 4'(s % 10)};
    endfunction

    function automatic int step_field(input int v, input int range, input bit up);
        return up ? (v + 1) % range : (v + range - 1) % range;
    endfunction

    ////////////////////////////////////////
    // cycle model, all reads are pre-edge
    ////////////////////////////////////////

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_fan_cycles = 0;
            m_tick       = 0;
            m_run        = 0;
            m_cd         = HURRICANE_SECS;
            m_state      = ST_ARMED;
            m_ms_prev    = 0;
            m_ret        = 0;
            m_done       = 0;
            m_adjust     = 0;
            m_field      = FIELD_SEC;
            m_rem_h      = REMINDER_DEFAULT_HR;
            m_rem_m      = 0;
            m_rem_s      = 0;
            m_sel        = 0;
            m_need       = 0;
            m_display    = expected_word(0, 0, 0);
        end else begin
            if (mode == MODE_GEAR1 || mode == MODE_GEAR2) m_sel = 0;
            else if (mode == MODE_HURRICANE) m_sel = 1;
            else if (mode == MODE_SHOW_REMINDER) m_sel = 2;
            case (m_sel)
                1:       m_display = expected_word(0, m_cd / 60, m_cd % 60);
                2:       m_display = expected_word(m_rem_h, m_rem_m, m_rem_s);
                default: m_display = expected_word(m_run / 3600, (m_run / 60) % 60, m_run % 60);
            endcase
            m_need = machine_state &&
                     (m_run >= m_rem_h * 3600 + m_rem_m * 60 + m_rem_s);

            // boost
            m_done = 0;
            if (machine_state && !m_ms_prev) begin
                m_state = ST_ARMED;
                m_cd    = HURRICANE_SECS;
            end else if (m_state == ST_ARMED && mode == MODE_HURRICANE) begin
                m_state = ST_RUNNING;
            end else if (m_state == ST_RUNNING && menu_btn) begin
                m_state = ST_SPENT;
                m_ret   = 0;
                m_done  = 1;
            end else if (m_state == ST_RUNNING && m_tick) begin
                if (m_cd == 0) begin
                    m_state = ST_SPENT;
                    m_ret   = 1;
                    m_done  = 1;
                end else begin
                    m_cd = m_cd - 1;
                end
            end
            m_ms_prev = machine_state;

            if (hand_clean) m_run = 0;
            else if (m_tick) m_run = (m_run + 1) % 86400;  // wraps after 23:59:59

            // threshold edits use the field before any step
            if (m_adjust && (btn_right || btn_left)) begin
                case (m_field)
                    FIELD_SEC: m_rem_s = step_field(m_rem_s, 60, btn_right);
                    FIELD_MIN: m_rem_m = step_field(m_rem_m, 60, btn_right);
                    default:   m_rem_h = step_field(m_rem_h, 24, btn_right);
                endcase
            end
            if (m_adjust && btn_up) begin
                case (m_field)
                    FIELD_SEC: m_field = FIELD_MIN;
                    FIELD_MIN: m_field = FIELD_HR;
                    default:   m_field = FIELD_SEC;
                endcase
            end
            if (btn_down && machine_state) m_adjust = !m_adjust;

            fan = (mode == MODE_GEAR1) || (mode == MODE_GEAR2) || (mode == MODE_HURRICANE);
            if (!fan || hand_clean) begin
                m_fan_cycles = 0;
                m_tick       = 0;
            end else begin
                m_fan_cycles = m_fan_cycles + 1;
                m_tick       = (m_fan_cycles == TICKS_PER_SEC);
                if (m_tick) m_fan_cycles = 0;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] expv,
                           input logic [31:0] actv);
        if (actv !== expv) begin
            mismatch_cnt++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expv, actv);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst) begin
            compare("display_data", m_display, display_data);
            compare("need_clean", 32'(m_need), 32'(need_clean));
            compare("return_state", 32'(m_ret), 32'(return_state));
            compare("hurricane_enabled", 32'(m_state != ST_SPENT), 32'(hurricane_enabled));
            compare("hurricane_done", 32'(m_done), 32'(hurricane_done));
        end
    end

endmodule

`default_nettype wire

// File: sim/hood_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hood_tb
    import hood_pkg::*;
();

    localparam int B_UP    = 0;
    localparam int B_LEFT  = 1;
    localparam int B_RIGHT = 2;
    localparam int B_DOWN  = 3;
    localparam int B_MENU  = 4;
    localparam int B_CLEAN = 5;

    logic      clk;
    logic      rst;
    mode_t     mode;
    logic      machine_state;
    logic      hand_clean;
    logic      menu_btn;
    logic      btn_up;
    logic      btn_left;
    logic      btn_right;
    logic      btn_down;
    bcd_time_t display_data;
    logic      return_state;
    logic      hurricane_enabled;
    logic      hurricane_done;
    logic      need_clean;
    int        timeouts = 0;
    int        total;

    always #2 clk = ~clk;  // 4 ns period

    hood_timer_top DUT (.*);
    hood_checker u_checker (.*);

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic set_mode(input mode_t m);
        @(posedge clk);
        mode <= m;
    endtask

    // one-cycle pulse, returns at the following falling edge
    task automatic press(input int which);
        @(posedge clk);
        case (which)
            B_UP:    btn_up     <= 1'b1;
            B_LEFT:  btn_left   <= 1'b1;
            B_RIGHT: btn_right  <= 1'b1;
            B_DOWN:  btn_down   <= 1'b1;
            B_MENU:  menu_btn   <= 1'b1;
            default: hand_clean <= 1'b1;
        endcase
        @(posedge clk);
        {btn_up, btn_left, btn_right, btn_down, menu_btn, hand_clean} <= '0;
        @(negedge clk);
    endtask

    task automatic power_cycle();
        @(posedge clk);
        machine_state <= 1'b0;
        run_cycles(3);
        machine_state <= 1'b1;
        run_cycles(3);
    endtask

    // sig 0 done, 1 need_clean, 2 enabled
    task automatic wait_level(input int sig, input bit level, input int limit,
                              input string what);
        bit seen;
        int n;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            case (sig)
                0:       seen = (hurricane_done == level);
                1:       seen = (need_clean == level);
                default: seen = (hurricane_enabled == level);
            endcase
        end
        if (!seen) begin
            timeouts++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    function automatic int rem_value(input field_t f);
        case (f)
            FIELD_SEC: return u_checker.m_rem_s;
            FIELD_MIN: return u_checker.m_rem_m;
            default:   return u_checker.m_rem_h;
        endcase
    endfunction

    task automatic set_field(input field_t f, input int target);
        int guard;
        guard = 0;
        while (u_checker.m_field != f && guard < 4) begin
            press(B_UP);
            guard++;
        end
        guard = 0;
        while (rem_value(f) != target && guard < 60) begin
            press(B_RIGHT);
            guard++;
        end
        if (u_checker.m_field != f || rem_value(f) != target) begin
            timeouts++;
            $display("could not set reminder field %0d to %0d", f, target);
        end
    endtask

    initial begin
        void'($urandom(32'h64e3_fd57));
        clk           = 1'b0;
        rst           = 1'b0;
        mode          = MODE_STANDBY;
        machine_state = 1'b0;
        {btn_up, btn_left, btn_right, btn_down, menu_btn, hand_clean} = '0;
        run_cycles(10);
        rst <= 1'b1;
        @(posedge clk);
        machine_state <= 1'b1;

        ////////////////////////////////////////
        // runtime in random gears
        ////////////////////////////////////////
        repeat (8) begin
            set_mode(mode_t'($urandom_range(1, 3)));
            run_cycles($urandom_range(200, 3000));
            set_mode(MODE_STANDBY);
            run_cycles($urandom_range(50, 500));
        end
        set_mode(MODE_GEAR1);
        press(B_CLEAN);
        run_cycles(2500);  // regrows from zero

        // boost runs out
        power_cycle();
        set_mode(MODE_HURRICANE);
        wait_level(0, 1'b1, 65 * TICKS_PER_SEC, "boost expiry");
        set_mode(MODE_GEAR2);
        run_cycles(200);
        set_mode(MODE_HURRICANE);  // spent, no restart
        run_cycles(2000);

        // abort with menu, then re-arm
        power_cycle();
        run_cycles(5 * TICKS_PER_SEC);
        press(B_MENU);
        wait_level(2, 1'b0, 10, "boost abort");
        set_mode(MODE_STANDBY);
        power_cycle();
        set_mode(MODE_HURRICANE);
        run_cycles(1500);
        set_mode(MODE_STANDBY);

        ////////////////////////////////////////
        // reminder threshold
        ////////////////////////////////////////
        set_mode(MODE_SHOW_REMINDER);
        press(B_DOWN);
        repeat (40) press($urandom_range(B_UP, B_DOWN));
        if (!u_checker.m_adjust) press(B_DOWN);
        set_field(FIELD_SEC, 5);
        set_field(FIELD_MIN, 0);
        set_field(FIELD_HR, 0);
        press(B_CLEAN);
        set_mode(MODE_GEAR1);
        wait_level(1, 1'b1, 6 * TICKS_PER_SEC, "need_clean rise");
        @(posedge clk);
        machine_state <= 1'b0;
        wait_level(1, 1'b0, 4, "need_clean fall");
        run_cycles(5);

        total = u_checker.mismatch_cnt + DUT.u_asserts.fails + timeouts;
        $display("errors: mismatches=%0d assertions=%0d timeouts=%0d",
                 u_checker.mismatch_cnt, DUT.u_asserts.fails, timeouts);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/hood_pkg.sv
hw/second_tick.sv
hw/runtime_counter.sv
hw/hurricane_ctrl.sv
hw/reminder_setting.sv
hw/display_formatter.sv
hw/hood_timer_top.sv
sim/hood_asserts.sv
sim/hood_checker.sv
sim/hood_tb.sv
